// ==== src.f ====
cps_mem_pkg.sv
cps_bus_pkg.sv
frac_cen.sv
prom_writer.sv
wb_mem_bridge.sv
vram_fetch.sv
sdram_slot_mux.sv
cps_mem_top.sv
mem_checker.sv
tb_cps_mem.sv

// ==== tb_cps_mem.sv ====
/*
 * Testbench of the memory side
 * Clock, reset, SDRAM controller model and random download,
 * CPU and scroll fetch traffic
 */
`timescale 1ns/100ps

module tb_cps_mem;

    localparam int WIN     = 256;      // Words used per region
    localparam int N_DL    = 32;
    localparam int N_ROM   = 24;
    localparam int N_RW    = 24;
    localparam int N_MIX   = 40;
    localparam int N_TRANS = N_DL + N_ROM + 8 + 2 * N_RW + 4 * cps_mem_pkg::FETCH_LEN + N_MIX;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       downloading;
    logic [22:0]                ioctl_addr;
    logic [7:0]                 ioctl_data;
    logic                       ioctl_wr;
    cps_bus_pkg::prog_t         prog;
    cps_bus_pkg::wb_req_t       wb_req;
    cps_bus_pkg::wb_rsp_t       wb_rsp;
    logic                       fetch_start;
    logic [15:0]                fetch_base;
    logic [15:0]                fetch_data;
    logic                       fetch_valid;
    logic                       fetch_done;
    logic                       sdram_req;
    logic [21:0]                sdram_addr;
    logic                       sdram_rnw;
    logic [1:0]                 sdram_wrmask;
    logic [15:0]                data_write;
    logic                       sdram_ack;
    logic                       data_rdy;
    cps_bus_pkg::sdram_word_u   data_read;
    logic [31:0]                sdram_mem [int];   // 32-bit lines

    always #10 clk = ~clk;

    cps_mem_top dut (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr), .prog(prog),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .fetch_start(fetch_start), .fetch_base(fetch_base), .fetch_data(fetch_data),
        .fetch_valid(fetch_valid), .fetch_done(fetch_done),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_rnw(sdram_rnw),
        .sdram_wrmask(sdram_wrmask), .data_write(data_write),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    mem_checker chk (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr), .prog(prog),
        .wb_req(wb_req), .wb_rsp(wb_rsp),
        .fetch_start(fetch_start), .fetch_base(fetch_base), .fetch_data(fetch_data),
        .fetch_valid(fetch_valid), .fetch_done(fetch_done), .sdram_req(sdram_req)
    );

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic preload_window(input int base);
        logic [31:0] w;
        for (int i = 0; i < WIN / 2; i++) begin
            w = $urandom;
            sdram_mem[base / 2 + i] = w;
            chk.set_ref(base + 2 * i, w[15:0]);          // Even word in the low half
            chk.set_ref(base + 2 * i + 1, w[31:16]);
        end
    endtask

    // Random CPU address inside the window of a region
    function automatic logic [18:0] window_adr(input logic [1:0] top);
        logic [31:0] rnd;
        rnd = $urandom_range(0, WIN - 1);
        return {top, 9'd0, rnd[7:0]};
    endfunction

    task automatic download_byte(input logic [22:0] addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        repeat ($urandom_range(0, 2)) next_cycle();
    endtask

    task automatic wb_access(input logic we, input logic [18:0] adr, input logic [1:0] sel,
                             input logic [15:0] dat);
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.dat = dat;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        @(posedge clk);
        while (!wb_rsp.ack) @(posedge clk);
        #2;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        next_cycle();   // stb stays low for a cycle
    endtask

    task automatic fetch_block(input logic [15:0] base);
        fetch_base  = base;
        fetch_start = 1'b1;
        next_cycle();
        fetch_start = 1'b0;
        @(posedge clk);
        while (!fetch_done) @(posedge clk);
        #2;
    endtask

    // VRAM stays untouched while the fetch block reads it
    task automatic mixed_access();
        logic [31:0] rnd;
        rnd = $urandom;
        case (rnd[1:0])
            2'd0: wb_access(1'b0, window_adr(2'b00), 2'b11, 16'h0000);
            2'd1: wb_access(1'b0, window_adr(2'b11), 2'b11, 16'h0000);
            2'd2: wb_access(1'b0, window_adr(2'b10), 2'b11, 16'h0000);
            default: wb_access(1'b1, window_adr(2'b10), rnd[3:2], rnd[31:16]);
        endcase
        repeat (rnd[5:4]) next_cycle();
    endtask

    // SDRAM controller model with random ack and data delays, one access at a time
    initial begin : sdram_model
        int          line;
        int          hsel;
        logic        rnw;
        logic [1:0]  mask;
        logic [15:0] wdata;
        logic [31:0] word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (rst_n && sdram_req) begin
                line  = sdram_addr[21:1];
                hsel  = sdram_addr[0];
                rnw   = sdram_rnw;
                mask  = sdram_wrmask;
                wdata = data_write;
                repeat ($urandom_range(0, 3)) @(posedge clk);
                #2 sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                repeat ($urandom_range(0, 3)) next_cycle();
                if (!sdram_mem.exists(line))
                    sdram_mem[line] = line * 32'h9e37_79b9;   // Outside the windows
                word = sdram_mem[line];
                if (!rnw && !mask[0]) word[16 * hsel +: 8] = wdata[7:0];
                if (!rnw && !mask[1]) word[16 * hsel + 8 +: 8] = wdata[15:8];
                sdram_mem[line] = word;
                data_read.word  = word;
                data_rdy        = 1'b1;
                next_cycle();
                data_rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (200 * N_TRANS + 2000) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", 200 * N_TRANS + 2000);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int unsigned  seed_ret;
        logic [18:0]  adr;
        logic [18:0]  adr_q [$];
        logic [31:0]  rnd;
        seed_ret    = $urandom(32'h0f48_5fef);
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        wb_req      = '0;
        fetch_start = 1'b0;
        fetch_base  = '0;
        preload_window(cps_mem_pkg::ROM_OFFSET);
        preload_window(cps_mem_pkg::RAM_OFFSET);
        preload_window(cps_mem_pkg::VRAM_OFFSET);
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();

        downloading = 1'b1;
        fork
            begin
                repeat (N_DL) begin
                    rnd = $urandom;
                    download_byte(rnd[22:0], rnd[30:23]);
                end
                downloading = 1'b0;
            end
            wb_access(1'b0, window_adr(2'b00), 2'b11, 16'h0000);   // Waits out the download
        join
        next_cycle();
        download_byte(23'h00_0123, 8'h5a);   // Dropped while no download runs
        repeat (3) next_cycle();
        chk.close_test("download packing");

        repeat (N_ROM) wb_access(1'b0, window_adr(2'b00), 2'b11, 16'h0000);
        repeat (4) begin
            adr = window_adr(2'b00);
            rnd = $urandom;
            wb_access(1'b1, adr, 2'b11, rnd[15:0]);
            wb_access(1'b0, adr, 2'b11, 16'h0000);
        end
        chk.close_test("CPU ROM reads");

        repeat (N_RW) begin
            rnd = $urandom;
            adr = window_adr({1'b1, rnd[16]});
            adr_q.push_back(adr);
            wb_access(1'b1, adr, rnd[1:0], rnd[31:16]);
        end
        foreach (adr_q[i]) wb_access(1'b0, adr_q[i], 2'b11, 16'h0000);
        chk.close_test("CPU RAM and VRAM writes");

        repeat (2) fetch_block($urandom_range(0, WIN - cps_mem_pkg::FETCH_LEN));
        chk.close_test("video fetch");

        fork
            repeat (2) fetch_block($urandom_range(0, WIN - cps_mem_pkg::FETCH_LEN));
            repeat (N_MIX) mixed_access();
        join
        chk.close_test("contention");

        chk.print_counts();
        if (chk.errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mem_checker.sv ====
/*
 * Scoreboard of the memory side
 * Watches the download, Wishbone, fetch and SDRAM ports and
 * checks them against its own reference memory
 */
`timescale 1ns/100ps

module mem_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,
    input  logic [22:0]             ioctl_addr,
    input  logic [7:0]              ioctl_data,
    input  logic                    ioctl_wr,
    input  cps_bus_pkg::prog_t      prog,
    input  cps_bus_pkg::wb_req_t    wb_req,
    input  cps_bus_pkg::wb_rsp_t    wb_rsp,
    input  logic                    fetch_start,
    input  logic [15:0]             fetch_base,
    input  logic [15:0]             fetch_data,
    input  logic                    fetch_valid,
    input  logic                    fetch_done,
    input  logic                    sdram_req
);

    logic [15:0]            ref_mem [int];      // 16-bit words by SDRAM word address
    int                     errors = 0;
    int                     checks = 0;
    int                     test_errs = 0;
    int                     test_checks = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    logic                   prog_due = 1'b0;
    cps_bus_pkg::prog_t     prog_exp;
    logic                   fetch_busy = 1'b0;
    logic                   done_due = 1'b0;
    int                     fetch_idx;
    logic [15:0]            base_q;

    // Maps a CPU address to its SDRAM word by the region in bits 18 and 17
    function automatic int cpu_word(input logic [18:0] adr);
        case (adr[18:17])
            2'b10:   return cps_mem_pkg::RAM_OFFSET + adr[16:0];
            2'b11:   return cps_mem_pkg::VRAM_OFFSET + adr[16:0];
            default: return cps_mem_pkg::ROM_OFFSET + adr[17:0];
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic check_word(input int waddr, input logic [15:0] got, input string what);
        checks++;
        test_checks++;
        if (!ref_mem.exists(waddr))
            report_error($sformatf("%s at %06h is outside the reference", what, waddr));
        else if (got !== ref_mem[waddr])
            report_error($sformatf("%s at %06h gave %04h, expected %04h",
                                   what, waddr, got, ref_mem[waddr]));
    endtask

    task automatic merge_write(input int waddr, input logic [1:0] sel, input logic [15:0] dat);
        logic [15:0] cur;
        cur = ref_mem.exists(waddr) ? ref_mem[waddr] : 16'h0000;
        if (sel[0]) cur[7:0] = dat[7:0];
        if (sel[1]) cur[15:8] = dat[15:8];
        ref_mem[waddr] = cur;
    endtask

    task automatic set_ref(input int waddr, input logic [15:0] val);
        ref_mem[waddr] = val;
    endtask

    task automatic close_test(input string name);
        if (test_checks == 0) report_error($sformatf("%s made no checks", name));
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s, %0d checks", name, test_checks);
        end else begin
            tests_failed++;
            $display("FAIL at %0t ns: %s, %0d errors in %0d checks",
                     $time, name, test_errs, test_checks);
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic print_counts();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
    endtask

    // One prog write per accepted download byte
    always @(posedge clk) begin
        if (rst_n) begin
            if (prog_due) begin
                checks++;
                test_checks++;
                if (prog.we !== prog_exp.we || prog.addr !== prog_exp.addr
                    || prog.data !== prog_exp.data || prog.mask !== prog_exp.mask)
                    report_error($sformatf("prog write %06h/%02h/%b, expected %06h/%02h/%b",
                                           prog.addr, prog.data, prog.mask,
                                           prog_exp.addr, prog_exp.data, prog_exp.mask));
            end else if (prog.we) begin
                report_error("prog write without a download byte");
            end
            if (downloading && sdram_req) report_error("sdram_req raised during a download");
        end
        prog_due      = rst_n && downloading && ioctl_wr;
        prog_exp.addr = ioctl_addr[22:1];
        prog_exp.data = ioctl_data;
        prog_exp.mask = 2'b11;
        prog_exp.mask[ioctl_addr[0]] = 1'b0;   // Addressed byte enabled
        prog_exp.we   = 1'b1;
    end

    // Every ack must fall inside a Wishbone cycle
    always @(posedge clk) begin
        if (rst_n && wb_rsp.ack) begin
            if (!(wb_req.cyc && wb_req.stb)) begin
                report_error("ack outside a Wishbone cycle");
            end else if (!wb_req.we) begin
                check_word(cpu_word(wb_req.adr), wb_rsp.dat, "CPU read");
            end else if (wb_req.adr[18:17] != 2'b00) begin   // ROM writes are dropped
                merge_write(cpu_word(wb_req.adr), wb_req.sel, wb_req.dat);
            end
        end
    end

    // FETCH_LEN fetch words in order and then one fetch_done
    always @(posedge clk) begin
        if (!rst_n) begin
            fetch_busy = 1'b0;
            done_due   = 1'b0;
        end else begin
            if (fetch_done !== done_due)
                report_error(done_due ? "fetch_done missing after the last word"
                                      : "fetch_done without a finished block");
            done_due = 1'b0;
            if (fetch_valid) begin
                if (!fetch_busy) begin
                    report_error("fetch_valid outside a fetch block");
                end else begin
                    check_word(cps_mem_pkg::VRAM_OFFSET + base_q + fetch_idx, fetch_data,
                               "fetch word");
                    fetch_idx++;
                    if (fetch_idx == cps_mem_pkg::FETCH_LEN) begin
                        fetch_busy = 1'b0;
                        done_due   = 1'b1;
                    end
                end
            end
            if (fetch_start) begin
                fetch_busy = 1'b1;
                base_q     = fetch_base;
                fetch_idx  = 0;
            end
        end
    end

endmodule

// ==== cps_mem_top.sv ====
/*
 * Memory side of the game core
 * Download packer, CPU bridge, scroll fetcher with its enable
 * and the SDRAM slot multiplexer
 */
`timescale 1ns/100ps

module cps_mem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // ROM download
    input  logic                        downloading,
    input  logic [22:0]                 ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    output cps_bus_pkg::prog_t          prog,
    // Main CPU
    input  cps_bus_pkg::wb_req_t        wb_req,
    output cps_bus_pkg::wb_rsp_t        wb_rsp,
    // Scroll fetch
    input  logic                        fetch_start,
    input  logic [15:0]                 fetch_base,
    output logic [15:0]                 fetch_data,
    output logic                        fetch_valid,
    output logic                        fetch_done,
    // SDRAM controller
    output logic                        sdram_req,
    output logic [21:0]                 sdram_addr,
    output logic                        sdram_rnw,
    output logic [1:0]                  sdram_wrmask,
    output logic [15:0]                 data_write,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  cps_bus_pkg::sdram_word_u    data_read
);

    cps_bus_pkg::slot_req_t slot_cpu;
    cps_bus_pkg::slot_req_t slot_vid;
    logic [1:0]             slot_ok;
    logic [15:0]            slot_dout;
    logic                   cen;

    frac_cen u_cen (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .cen    ( cen   )
    );

    prom_writer u_prom (
        .clk            ( clk           ),
        .rst_n          ( rst_n         ),
        .downloading    ( downloading   ),
        .ioctl_addr     ( ioctl_addr    ),
        .ioctl_data     ( ioctl_data    ),
        .ioctl_wr       ( ioctl_wr      ),
        .prog           ( prog          )
    );

    wb_mem_bridge u_bridge (
        .clk        ( clk                               ),
        .rst_n      ( rst_n                             ),
        .wb_req     ( wb_req                            ),
        .wb_rsp     ( wb_rsp                            ),
        .slot       ( slot_cpu                          ),
        .slot_ok    ( slot_ok[cps_mem_pkg::SLOT_CPU]    ),
        .slot_dout  ( slot_dout                         )
    );

    vram_fetch u_fetch (
        .clk            ( clk                               ),
        .rst_n          ( rst_n                             ),
        .cen            ( cen                               ),
        .fetch_start    ( fetch_start                       ),
        .fetch_base     ( fetch_base                        ),
        .slot           ( slot_vid                          ),
        .slot_ok        ( slot_ok[cps_mem_pkg::SLOT_VID]    ),
        .slot_dout      ( slot_dout                         ),
        .fetch_data     ( fetch_data                        ),
        .fetch_valid    ( fetch_valid                       ),
        .fetch_done     ( fetch_done                        )
    );

    sdram_slot_mux u_mux (
        .clk            ( clk           ),
        .rst_n          ( rst_n         ),
        .downloading    ( downloading   ),
        .slot_cpu       ( slot_cpu      ),
        .slot_vid       ( slot_vid      ),
        .slot_ok        ( slot_ok       ),
        .slot_dout      ( slot_dout     ),
        .sdram_req      ( sdram_req     ),
        .sdram_addr     ( sdram_addr    ),
        .sdram_rnw      ( sdram_rnw     ),
        .sdram_wrmask   ( sdram_wrmask  ),
        .data_write     ( data_write    ),
        .sdram_ack      ( sdram_ack     ),
        .data_rdy       ( data_rdy      ),
        .data_read      ( data_read     )
    );

endmodule

// ==== sdram_slot_mux.sv ====
/*
 * SDRAM slot multiplexer
 * Grants the CPU and video slots by fixed priority onto the single
 * controller port, one access at a time, and holds off during a download
 */
`timescale 1ns/100ps

module sdram_slot_mux (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  cps_bus_pkg::slot_req_t      slot_cpu,
    input  cps_bus_pkg::slot_req_t      slot_vid,
    output logic [1:0]                  slot_ok,
    output logic [15:0]                 slot_dout,
    output logic                        sdram_req,
    output logic [21:0]                 sdram_addr,
    output logic                        sdram_rnw,
    output logic [1:0]                  sdram_wrmask,
    output logic [15:0]                 data_write,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  cps_bus_pkg::sdram_word_u    data_read
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ACK  = 2'd1,
        ST_DATA = 2'd2
    } state_e;

    state_e                     state;
    cps_bus_pkg::slot_req_t     req [2];
    cps_bus_pkg::slot_req_t     win;
    logic                       vid_go;
    logic                       cpu_go;
    logic                       pick;
    logic                       grant;
    logic                       gnt;
    logic                       half_q;

    assign req[cps_mem_pkg::SLOT_CPU] = slot_cpu;
    assign req[cps_mem_pkg::SLOT_VID] = slot_vid;

    // A slot still shows cs in its slot_ok cycle, skip it there
    assign vid_go = slot_vid.cs & ~slot_ok[cps_mem_pkg::SLOT_VID];
    assign cpu_go = slot_cpu.cs & ~slot_ok[cps_mem_pkg::SLOT_CPU];

    assign pick  = vid_go ? cps_mem_pkg::SLOT_VID : cps_mem_pkg::SLOT_CPU;
    assign win   = req[pick];
    assign grant = (state == ST_IDLE) & ~downloading & (vid_go | cpu_go);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            slot_ok   <= 2'b00;
        end else begin
            slot_ok <= 2'b00;
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        sdram_req <= 1'b1;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin
                        slot_ok[gnt] <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    sdram_req <= 1'b0;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

    // Request fields stay put until the next grant
    always_ff @(posedge clk) begin
        if (grant) begin
            gnt          <= pick;
            sdram_addr   <= win.addr;      // Bit 0 picks the half of the 32-bit line
            sdram_rnw    <= ~win.we;
            sdram_wrmask <= win.wrmask;
            data_write   <= win.din;
            half_q       <= win.addr[0];
        end
        if (state == ST_DATA && data_rdy) begin
            slot_dout <= data_read.half[half_q];
        end
    end

endmodule

// ==== vram_fetch.sv ====
/*
 * Scroll VRAM block reader
 * Walks FETCH_LEN words from a base on enable pulses and
 * streams each returned word out
 */
`timescale 1ns/100ps

module vram_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     fetch_start,
    input  logic [15:0]              fetch_base,
    output cps_bus_pkg::slot_req_t   slot,
    input  logic                     slot_ok,
    input  logic [15:0]              slot_dout,
    output logic [15:0]              fetch_data,
    output logic                     fetch_valid,
    output logic                     fetch_done
);

    logic                                 active;
    logic                                 pending;
    logic                                 issue;
    logic                                 got;
    logic                                 last_idx;
    logic                                 last_word;
    logic [cps_mem_pkg::FETCH_IW-1:0]     idx;
    logic [15:0]                          base_q;
    logic [cps_mem_pkg::ADDR_W-1:0]       addr_q;

    assign issue    = cen & active & ~pending & ~fetch_start;
    assign got      = pending & slot_ok;
    assign last_idx = idx == cps_mem_pkg::FETCH_LEN - 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active      <= 1'b0;
            pending     <= 1'b0;
            idx         <= '0;
            fetch_valid <= 1'b0;
            last_word   <= 1'b0;
            fetch_done  <= 1'b0;
        end else begin
            fetch_valid <= got;
            last_word   <= got & last_idx;
            fetch_done  <= last_word;     // One cycle after the last word
            if (fetch_start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (got) begin
                idx <= idx + 1'b1;
                if (last_idx) active <= 1'b0;
            end
            if (got) begin
                pending <= 1'b0;
            end else if (issue) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) base_q <= fetch_base;
        if (issue) addr_q <= cps_mem_pkg::VRAM_OFFSET + base_q + idx;
        if (got) fetch_data <= slot_dout;
    end

    // Read-only slot
    assign slot = '{cs: pending, we: 1'b0, addr: addr_q, wrmask: 2'b11, din: 16'h0000};

endmodule

// ==== wb_mem_bridge.sv ====
/*
 * Wishbone classic slave for the main CPU
 * Decodes ROM, RAM and VRAM from the top address bits, adds the
 * region offset and holds a slot request until the multiplexer answers
 */
`timescale 1ns/100ps

module wb_mem_bridge (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cps_bus_pkg::wb_req_t     wb_req,
    output cps_bus_pkg::wb_rsp_t     wb_rsp,
    output cps_bus_pkg::slot_req_t   slot,
    input  logic                     slot_ok,
    input  logic [15:0]              slot_dout
);

    cps_mem_pkg::region_e                 region;
    logic [cps_mem_pkg::ADDR_W-1:0]       req_addr;
    logic                                 access;
    logic                                 bypass;
    logic                                 start;
    logic                                 done;
    logic                                 busy;
    logic                                 we_q;
    logic [cps_mem_pkg::ADDR_W-1:0]       addr_q;
    logic [1:0]                           wrmask_q;
    logic [15:0]                          din_q;
    logic [15:0]                          dat_q;

    always_comb begin
        case (wb_req.adr[cps_mem_pkg::CPU_AW-1 -: 2])
            2'b00, 2'b01: region = cps_mem_pkg::REGION_ROM;
            2'b10:        region = cps_mem_pkg::REGION_RAM;
            2'b11:        region = cps_mem_pkg::REGION_VRAM;
            default:      region = cps_mem_pkg::REGION_NONE;
        endcase
    end

    always_comb begin
        case (region)
            cps_mem_pkg::REGION_ROM:
                req_addr = cps_mem_pkg::ROM_OFFSET + wb_req.adr[cps_mem_pkg::ROM_AW-1:0];
            cps_mem_pkg::REGION_RAM:
                req_addr = cps_mem_pkg::RAM_OFFSET + wb_req.adr[cps_mem_pkg::RAM_AW-1:0];
            cps_mem_pkg::REGION_VRAM:
                req_addr = cps_mem_pkg::VRAM_OFFSET + wb_req.adr[cps_mem_pkg::RAM_AW-1:0];
            default:
                req_addr = '0;
        endcase
    end

    assign access = wb_req.cyc & wb_req.stb;

    // ROM writes and unmapped cycles never reach SDRAM
    assign bypass = access & ((region == cps_mem_pkg::REGION_ROM && wb_req.we)
                              || region == cps_mem_pkg::REGION_NONE);
    assign start  = access & ~bypass & ~busy;
    assign done   = busy & slot_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q     <= wb_req.we;
            addr_q   <= req_addr;
            wrmask_q <= wb_req.we ? ~wb_req.sel : 2'b11;   // Reads touch no byte
            din_q    <= wb_req.dat;
        end
        if (done) begin
            dat_q <= slot_dout;
        end
    end

    assign slot = '{cs: busy, we: we_q, addr: addr_q, wrmask: wrmask_q, din: din_q};

    // Answer in the slot_ok cycle, data passes straight through then
    assign wb_rsp.ack = (done & access) | bypass;
    assign wb_rsp.dat = done ? slot_dout : dat_q;

endmodule

// ==== prom_writer.sv ====
/*
 * Download packer
 * Turns ioctl bytes into 16-bit prog writes with an
 * active-low byte mask, one cycle after each ioctl_wr
 */
`timescale 1ns/100ps

module prom_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  logic [22:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output cps_bus_pkg::prog_t   prog
);

    logic                                 take;
    logic [cps_mem_pkg::ADDR_W-1:0]       addr_q;
    logic [7:0]                           data_q;
    logic [1:0]                           mask_q;
    logic                                 we_q;

    assign take = ioctl_wr & downloading;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= ioctl_addr[22:1];                     // Byte to word
            data_q <= ioctl_data;
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;        // Even byte is the low one
        end
    end

    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

endmodule

// ==== frac_cen.sv ====
/*
 * Fractional clock enable
 * Single-cycle pulses at an average of CEN_N per CEN_M clocks,
 * paces the video fetcher
 */
`timescale 1ns/100ps

module frac_cen (
    input  logic clk,
    input  logic rst_n,
    output logic cen
);

    logic [$bits(cps_mem_pkg::CEN_M):0] acc;
    logic [$bits(cps_mem_pkg::CEN_M):0] sum;

    assign sum = acc + cps_mem_pkg::CEN_N;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (sum >= cps_mem_pkg::CEN_M) begin
            acc <= sum - cps_mem_pkg::CEN_M;   // Keep the remainder
            cen <= 1'b1;
        end else begin
            acc <= sum;
            cen <= 1'b0;
        end
    end

endmodule

// ==== cps_bus_pkg.sv ====
/*
 * Bus types of the memory side
 * Wishbone request and response, slot requests, SDRAM read word
 * and the download write
 */
package cps_bus_pkg;

    typedef struct packed {
        logic                              cyc;
        logic                              stb;
        logic                              we;
        logic [cps_mem_pkg::CPU_AW-1:0]    adr;
        logic [1:0]                        sel;
        logic [15:0]                       dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                              cs;
        logic                              we;
        logic [cps_mem_pkg::ADDR_W-1:0]    addr;
        logic [1:0]                        wrmask;  // Active low
        logic [15:0]                       din;
    } slot_req_t;

    // SDRAM line, whole or as two halves. half[0] is the even word
    typedef union packed {
        logic [31:0]        word;
        logic [1:0][15:0]   half;
    } sdram_word_u;

    typedef struct packed {
        logic [cps_mem_pkg::ADDR_W-1:0]    addr;
        logic [7:0]                        data;
        logic [1:0]                        mask;
        logic                              we;
    } prog_t;

endpackage

// ==== cps_mem_pkg.sv ====
/*
 * Memory map of the game core
 * Region offsets in SDRAM, CPU region codes, slot numbering
 * and the pacing of the video fetcher
 */
package cps_mem_pkg;

    // SDRAM side, 16-bit word addresses
    localparam int ADDR_W = 22;

    // CPU side word address
    localparam int CPU_AW = 19;

    // Low CPU address bits kept per region
    localparam int ROM_AW = 18;    // 0x covers half the CPU space
    localparam int RAM_AW = 17;

    localparam logic [ADDR_W-1:0] ROM_OFFSET  = 22'h00_0000;
    localparam logic [ADDR_W-1:0] RAM_OFFSET  = 22'h3A_8000;
    localparam logic [ADDR_W-1:0] VRAM_OFFSET = 22'h3B_0000;

    // Region decoded from CPU address bits 18 and 17
    typedef enum logic [1:0] {
        REGION_ROM  = 2'd0,
        REGION_RAM  = 2'd1,
        REGION_VRAM = 2'd2,
        REGION_NONE = 2'd3
    } region_e;

    // Slot numbering at the multiplexer
    localparam logic SLOT_CPU = 1'b0;
    localparam logic SLOT_VID = 1'b1;

    // One scroll block
    localparam int FETCH_LEN = 16;
    localparam int FETCH_IW  = $clog2(FETCH_LEN);

    // Fetch enable ratio, n over m
    localparam logic [9:0] CEN_N = 10'd5;
    localparam logic [9:0] CEN_M = 10'd24;

endpackage
